// File: verilog/srcnn_pkg.sv
package srcnn_pkg;

    localparam int Height = 8;
    localparam int Width = 8;

    localparam int ActivationWidth = 8;
    localparam int MaxActivation = 2 ** ActivationWidth - 1;

    localparam int ColorChannels = 3;
    localparam int N1 = 4;
    localparam int N2 = 4;
    localparam int MaxChannels = (N1 > N2) ? ((N1 > ColorChannels) ? N1 : ColorChannels) :
                                             ((N2 > ColorChannels) ? N2 : ColorChannels);

    localparam int KernelSize = 3;
    localparam int Padding = KernelSize / 2;

    // row-major taps, shared by every channel pair.
    localparam bit [7:0] Kernel [KernelSize*KernelSize] = '{
        8'd1, 8'd2, 8'd1,
        8'd2, 8'd4, 8'd2,
        8'd1, 8'd2, 8'd1
    };
    localparam int OutputShift = 6;

    localparam int FifoDepth = 4;

    localparam int RowWidth = $clog2(Height);
    localparam int ColWidth = $clog2(Width);
    localparam int SlotWidth = $clog2(KernelSize);
    localparam int BufferDepth = KernelSize * Width;  // one slot row per kernel row.
    // how far input may run ahead of the window before it overwrites a needed pixel.
    localparam int PendingLimit = (KernelSize - Padding) * Width - Padding;
    localparam int PendingWidth = $clog2(PendingLimit + 1);

    typedef bit [ActivationWidth-1:0] activation_t;

    typedef struct packed {
        activation_t b;
        activation_t g;
        activation_t r;  // channel 0 in the low bits.
    } rgb_pixel_t;

endpackage : srcnn_pkg

// File: verilog/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter int DataWidth = 8,
    parameter int Depth = 4
) (
    input bit clock_i,
    input bit reset_i,

    input bit slave_valid_i,
    output bit slave_ready_o,
    input bit [DataWidth-1:0] slave_data_i,

    output bit master_valid_o,
    input bit master_ready_i,
    output bit [DataWidth-1:0] master_data_o
);

    bit [DataWidth-1:0] storage [Depth];
    bit [$clog2(Depth)-1:0] read_pointer;
    bit [$clog2(Depth)-1:0] write_pointer;
    bit [$clog2(Depth+1)-1:0] count;
    bit push;
    bit pop;

    assign slave_ready_o = count < Depth;
    assign master_valid_o = count != 0;
    assign master_data_o = storage[read_pointer];

    assign push = slave_valid_i && slave_ready_o;
    assign pop = master_valid_o && master_ready_i;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            read_pointer <= '0;
            write_pointer <= '0;
            count <= '0;
        end else begin
            if (push) begin
                write_pointer <= (write_pointer == Depth - 1) ? '0 : write_pointer + 1'b1;
            end
            if (pop) begin
                read_pointer <= (read_pointer == Depth - 1) ? '0 : read_pointer + 1'b1;
            end
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;  // both or neither.
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (push) begin
            storage[write_pointer] <= slave_data_i;
        end
    end

    assert property (@(posedge clock_i) disable iff (reset_i) count <= Depth)
        else $error("stream_fifo occupancy above depth");

    // a stalled head entry must not move under the consumer.
    assert property (@(posedge clock_i) disable iff (reset_i)
        master_valid_o && !master_ready_i |=> $stable(master_data_o))
        else $error("stream_fifo output changed while stalled");

endmodule : stream_fifo

// File: verilog/window_buffer.sv
`timescale 1ns/1ps

module window_buffer import srcnn_pkg::*; #(
    parameter int Channels = 3
) (
    input bit clock_i,
    input bit reset_i,

    input bit slave_valid_i,
    output bit slave_ready_o,
    input bit [Channels*ActivationWidth-1:0] slave_data_i,

    output bit master_valid_o,
    input bit master_ready_i,
    output bit [KernelSize*KernelSize*Channels*ActivationWidth-1:0] master_window_o
);

    typedef struct packed {
        bit [RowWidth-1:0] row;
        bit [ColWidth-1:0] col;
        bit [SlotWidth-1:0] slot;  // line slot, keeps rotating across frames.
    } position_t;

    bit [Channels*ActivationWidth-1:0] lines [BufferDepth];

    position_t in_pos;
    position_t out_pos;
    bit [PendingWidth-1:0] pending;  // pixels received beyond the current window centre.
    int needed;
    bit push;
    bit pop;

    function automatic position_t advance(input position_t position);
        position_t next;
        next = position;
        if (position.col == ColWidth'(Width - 1)) begin
            next.col = '0;
            next.row = (position.row == RowWidth'(Height - 1)) ? '0 : position.row + 1'b1;
            next.slot = (position.slot == SlotWidth'(KernelSize - 1)) ? '0 : position.slot + 1'b1;
        end else begin
            next.col = position.col + 1'b1;
        end
        return next;
    endfunction

    assign push = slave_valid_i && slave_ready_o;
    assign pop = master_valid_o && master_ready_i;

    assign slave_ready_o = pending < PendingLimit;
    assign master_valid_o = int'(pending) >= needed;

    // rows below and columns right of the centre are clipped at the image edge,
    // so the last row flushes from stored lines.
    always_comb begin
        int below;
        int right;
        below = (int'(out_pos.row) + Padding < Height) ? Padding : Height - 1 - int'(out_pos.row);
        right = (int'(out_pos.col) + Padding < Width) ? Padding : Width - 1 - int'(out_pos.col);
        needed = below * Width + right + 1;
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            in_pos <= '0;
            out_pos <= '0;
            pending <= '0;
        end else begin
            if (push) begin
                in_pos <= advance(in_pos);
            end
            if (pop) begin
                out_pos <= advance(out_pos);
            end
            case ({push, pop})
                2'b10: pending <= pending + 1'b1;
                2'b01: pending <= pending - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clock_i) begin
        if (push) begin
            lines[int'(in_pos.slot) * Width + int'(in_pos.col)] <= slave_data_i;
        end
    end

    // taps outside the image read as zero.
    always_comb begin
        int row;
        int col;
        int slot;
        master_window_o = '0;
        for (int dy = 0; dy < KernelSize; dy++) begin
            for (int dx = 0; dx < KernelSize; dx++) begin
                row = int'(out_pos.row) + dy - Padding;
                col = int'(out_pos.col) + dx - Padding;
                slot = (int'(out_pos.slot) + dy - Padding + KernelSize) % KernelSize;
                if (row >= 0 && row < Height && col >= 0 && col < Width) begin
                    master_window_o[(dy * KernelSize + dx) * Channels * ActivationWidth +:
                                    Channels * ActivationWidth] = lines[slot * Width + col];
                end
            end
        end
    end

    // before the last rows, a window is only offered once its lower row has started.
    assert property (@(posedge clock_i) disable iff (reset_i)
        master_valid_o && out_pos.row < Height - KernelSize + Padding |->
            in_pos.row > out_pos.row)
        else $error("window_buffer output overtook input");

endmodule : window_buffer

// File: verilog/convolve.sv
`timescale 1ns/1ps

module convolve import srcnn_pkg::*; #(
    parameter int InChannels = 3,
    parameter int OutChannels = 4
) (
    input bit clock_i,
    input bit reset_i,

    input bit slave_valid_i,
    output bit slave_ready_o,
    input bit [InChannels*ActivationWidth-1:0] slave_data_i,

    output bit master_valid_o,
    input bit master_ready_i,
    output bit [OutChannels*ActivationWidth-1:0] master_data_o
);

    bit window_valid;
    bit window_ready;
    bit [KernelSize*KernelSize*InChannels*ActivationWidth-1:0] window;
    bit [OutChannels*ActivationWidth-1:0] result;

    window_buffer #(
        .Channels(InChannels)
    ) window_buffer_inst (
        .clock_i(clock_i),
        .reset_i(reset_i),

        .slave_valid_i(slave_valid_i),
        .slave_ready_o(slave_ready_o),
        .slave_data_i (slave_data_i),

        .master_valid_o (window_valid),
        .master_ready_i (window_ready),
        .master_window_o(window)
    );

    // result register takes a new window when empty or being drained.
    assign window_ready = !master_valid_o || master_ready_i;

    // each output channel has its own adder tree, even with one shared kernel.
    always_comb begin
        int unsigned sum;
        int unsigned scaled;
        activation_t tap;
        for (int o = 0; o < OutChannels; o++) begin
            sum = 0;
            for (int t = 0; t < KernelSize * KernelSize; t++) begin
                for (int c = 0; c < InChannels; c++) begin
                    tap = window[(t * InChannels + c) * ActivationWidth +: ActivationWidth];
                    sum += Kernel[t] * tap;
                end
            end
            scaled = sum >> OutputShift;
            result[o * ActivationWidth +: ActivationWidth] =
                (scaled > MaxActivation) ? activation_t'(MaxActivation) : activation_t'(scaled);
        end
    end

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            master_valid_o <= 1'b0;
        end else if (window_ready) begin
            master_valid_o <= window_valid;
        end
    end

    always_ff @(posedge clock_i) begin
        if (window_valid && window_ready) begin
            master_data_o <= result;  // saturated, never wraps.
        end
    end

    assert property (@(posedge clock_i) reset_i |=> !master_valid_o)
        else $error("convolve output valid after reset");

endmodule : convolve

// File: verilog/srcnn_small.sv
`timescale 1ns/1ps

module srcnn_small import srcnn_pkg::*; (
    input bit clock_i,
    input bit reset_i,

    input bit slave_valid_i,
    output bit slave_ready_o,
    input rgb_pixel_t slave_data_i,

    output bit master_valid_o,
    input bit master_ready_i,
    output rgb_pixel_t master_data_o
);

    bit fifo_a_valid;
    bit fifo_a_ready;
    bit [ColorChannels*ActivationWidth-1:0] fifo_a_data;

    bit convolve1_valid;
    bit convolve1_ready;
    bit [N1*ActivationWidth-1:0] convolve1_data;

    bit fifo_b_valid;
    bit fifo_b_ready;
    bit [N1*ActivationWidth-1:0] fifo_b_data;

    bit convolve2_valid;
    bit convolve2_ready;
    bit [N2*ActivationWidth-1:0] convolve2_data;

    bit fifo_c_valid;
    bit fifo_c_ready;
    bit [N2*ActivationWidth-1:0] fifo_c_data;

    bit convolve3_valid;
    bit convolve3_ready;
    bit [ColorChannels*ActivationWidth-1:0] convolve3_data;

    stream_fifo #(.DataWidth($bits(rgb_pixel_t)), .Depth(FifoDepth)) fifo_a_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(slave_valid_i), .slave_ready_o(slave_ready_o),
        .slave_data_i(slave_data_i),
        .master_valid_o(fifo_a_valid), .master_ready_i(fifo_a_ready),
        .master_data_o(fifo_a_data)
    );

    convolve #(.InChannels(ColorChannels), .OutChannels(N1)) convolve1_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(fifo_a_valid), .slave_ready_o(fifo_a_ready), .slave_data_i(fifo_a_data),
        .master_valid_o(convolve1_valid), .master_ready_i(convolve1_ready),
        .master_data_o(convolve1_data)
    );

    stream_fifo #(.DataWidth(N1 * ActivationWidth), .Depth(FifoDepth)) fifo_b_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(convolve1_valid), .slave_ready_o(convolve1_ready),
        .slave_data_i(convolve1_data),
        .master_valid_o(fifo_b_valid), .master_ready_i(fifo_b_ready), .master_data_o(fifo_b_data)
    );

    convolve #(.InChannels(N1), .OutChannels(N2)) convolve2_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(fifo_b_valid), .slave_ready_o(fifo_b_ready), .slave_data_i(fifo_b_data),
        .master_valid_o(convolve2_valid), .master_ready_i(convolve2_ready),
        .master_data_o(convolve2_data)
    );

    stream_fifo #(.DataWidth(N2 * ActivationWidth), .Depth(FifoDepth)) fifo_c_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(convolve2_valid), .slave_ready_o(convolve2_ready),
        .slave_data_i(convolve2_data),
        .master_valid_o(fifo_c_valid), .master_ready_i(fifo_c_ready), .master_data_o(fifo_c_data)
    );

    convolve #(.InChannels(N2), .OutChannels(ColorChannels)) convolve3_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(fifo_c_valid), .slave_ready_o(fifo_c_ready), .slave_data_i(fifo_c_data),
        .master_valid_o(convolve3_valid), .master_ready_i(convolve3_ready),
        .master_data_o(convolve3_data)
    );

    // output side, back to rgb packing.
    stream_fifo #(.DataWidth($bits(rgb_pixel_t)), .Depth(FifoDepth)) fifo_d_inst (
        .clock_i(clock_i), .reset_i(reset_i),
        .slave_valid_i(convolve3_valid), .slave_ready_o(convolve3_ready),
        .slave_data_i(convolve3_data),
        .master_valid_o(master_valid_o), .master_ready_i(master_ready_i),
        .master_data_o(master_data_o)
    );

endmodule : srcnn_small

// File: test/srcnn_model.svh
`ifndef SRCNN_MODEL_SVH
`define SRCNN_MODEL_SVH

// one plane per channel, sized for the widest layer.
typedef srcnn_pkg::activation_t model_image_t
    [srcnn_pkg::Height][srcnn_pkg::Width][srcnn_pkg::MaxChannels];

// 3x3 convolution with zero padding, shift and saturation.
function automatic model_image_t model_layer(
    input model_image_t in_image,
    input int in_channels,
    input int out_channels
);
    model_image_t out_image;
    int unsigned sum;
    int unsigned scaled;
    int row;
    int col;
    out_image = '{default: '0};
    for (int y = 0; y < srcnn_pkg::Height; y++) begin
        for (int x = 0; x < srcnn_pkg::Width; x++) begin
            for (int o = 0; o < out_channels; o++) begin
                sum = 0;
                for (int ky = 0; ky < srcnn_pkg::KernelSize; ky++) begin
                    for (int kx = 0; kx < srcnn_pkg::KernelSize; kx++) begin
                        row = y + ky - srcnn_pkg::Padding;
                        col = x + kx - srcnn_pkg::Padding;
                        if (row >= 0 && row < srcnn_pkg::Height &&
                            col >= 0 && col < srcnn_pkg::Width) begin
                            for (int c = 0; c < in_channels; c++) begin
                                sum += srcnn_pkg::Kernel[ky * srcnn_pkg::KernelSize + kx] *
                                       in_image[row][col][c];
                            end
                        end
                    end
                end
                scaled = sum >> srcnn_pkg::OutputShift;
                if (scaled > srcnn_pkg::MaxActivation) begin
                    scaled = srcnn_pkg::MaxActivation;
                end
                out_image[y][x][o] = srcnn_pkg::activation_t'(scaled);
            end
        end
    end
    return out_image;
endfunction

// all three stages, rgb in and rgb out.
function automatic model_image_t model_srcnn(input model_image_t rgb_image);
    model_image_t hidden1;
    model_image_t hidden2;
    hidden1 = model_layer(rgb_image, srcnn_pkg::ColorChannels, srcnn_pkg::N1);
    hidden2 = model_layer(hidden1, srcnn_pkg::N1, srcnn_pkg::N2);
    return model_layer(hidden2, srcnn_pkg::N2, srcnn_pkg::ColorChannels);
endfunction

`endif

// File: test/srcnn_small_tb.sv
`timescale 1ns/1ps

module srcnn_small_tb import srcnn_pkg::*; ();

    `include "srcnn_model.svh"

    localparam int TimeoutCycles = 2000;
    localparam int DrainCycles = 20;
    localparam int ImpulseRow = 3;
    localparam int ImpulseCol = 4;

    typedef enum int {ImageConstant, ImageImpulse, ImageRandom} image_kind_t;

    typedef struct {
        string name;
        image_kind_t kind;
        int value;
        int frames;
        bit stall;  // randomly drop master_ready_i.
    } test_row_t;

    test_row_t tests [5] = '{
        '{"constant_40", ImageConstant, 40, 1, 1'b0},
        '{"impulse_r", ImageImpulse, 255, 1, 1'b0},
        '{"constant_255", ImageConstant, 255, 1, 1'b0},
        '{"random_stall", ImageRandom, 0, 1, 1'b1},
        '{"two_frames", ImageRandom, 0, 2, 1'b0}
    };

    bit clock_i = 1'b0;
    bit reset_i;
    bit slave_valid_i;
    bit slave_ready_o;
    rgb_pixel_t slave_data_i;
    bit master_valid_o;
    bit master_ready_i;
    rgb_pixel_t master_data_o;

    int seed = int'(32'hd6b4c04d);
    model_image_t input_images [2];
    model_image_t expected_images [2];

    srcnn_small i_dut (
        .clock_i(clock_i),
        .reset_i(reset_i),
        .slave_valid_i(slave_valid_i),
        .slave_ready_o(slave_ready_o),
        .slave_data_i(slave_data_i),
        .master_valid_o(master_valid_o),
        .master_ready_i(master_ready_i),
        .master_data_o(master_data_o)
    );

    always #4 clock_i = !clock_i;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped after a failure");
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            stop_run($sformatf("FAILED %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    function automatic model_image_t build_image(input image_kind_t kind, input int value);
        model_image_t image;
        image = '{default: '0};
        for (int y = 0; y < Height; y++) begin
            for (int x = 0; x < Width; x++) begin
                for (int c = 0; c < ColorChannels; c++) begin
                    if (kind == ImageConstant) begin
                        image[y][x][c] = activation_t'(value);
                    end else if (kind == ImageRandom) begin
                        image[y][x][c] = activation_t'($random(seed));
                    end
                end
            end
        end
        if (kind == ImageImpulse) begin
            image[ImpulseRow][ImpulseCol][0] = activation_t'(value);  // r channel only.
        end
        return image;
    endfunction

    // called on a falling edge, returns on the falling edge after the transfer.
    task automatic send_pixel(input rgb_pixel_t pixel);
        int cycles;
        cycles = 0;
        slave_valid_i = 1'b1;
        slave_data_i = pixel;
        while (!slave_ready_o) begin  // depends on fifo occupancy only.
            @(negedge clock_i);
            cycles++;
            if (cycles > TimeoutCycles) begin
                stop_run("input pixel was not accepted within the timeout");
            end
        end
        @(negedge clock_i);
    endtask

    task automatic drive_frames(input int frames);
        rgb_pixel_t pixel;
        for (int f = 0; f < frames; f++) begin
            for (int y = 0; y < Height; y++) begin
                for (int x = 0; x < Width; x++) begin
                    pixel.r = input_images[f][y][x][0];
                    pixel.g = input_images[f][y][x][1];
                    pixel.b = input_images[f][y][x][2];
                    send_pixel(pixel);
                end
            end
        end
        slave_valid_i = 1'b0;
    endtask

    task automatic collect_pixel(input bit stall, output rgb_pixel_t pixel);
        int cycles;
        bit taken;
        cycles = 0;
        taken = 1'b0;
        pixel = '0;
        while (!taken) begin
            @(negedge clock_i);
            master_ready_i = stall ? (($random(seed) % 2) == 0) : 1'b1;
            if (master_valid_o && master_ready_i) begin
                pixel = master_data_o;  // taken on the next rising edge.
                taken = 1'b1;
            end
            cycles++;
            if (cycles > TimeoutCycles) begin
                stop_run("output pixel did not arrive within the timeout");
            end
        end
    endtask

    task automatic collect_frames(input test_row_t test);
        rgb_pixel_t pixel;
        string where;
        for (int f = 0; f < test.frames; f++) begin
            for (int y = 0; y < Height; y++) begin
                for (int x = 0; x < Width; x++) begin
                    collect_pixel(test.stall, pixel);
                    where = $sformatf("%s frame %0d pixel (%0d,%0d)", test.name, f, y, x);
                    check_value({where, " r"}, expected_images[f][y][x][0], pixel.r);
                    check_value({where, " g"}, expected_images[f][y][x][1], pixel.g);
                    check_value({where, " b"}, expected_images[f][y][x][2], pixel.b);
                end
            end
        end
    endtask

    task automatic run_test(input test_row_t test);
        for (int f = 0; f < test.frames; f++) begin
            input_images[f] = build_image(test.kind, test.value);
            expected_images[f] = model_srcnn(input_images[f]);
        end
        @(negedge clock_i);
        fork
            drive_frames(test.frames);
            collect_frames(test);
        join
        @(negedge clock_i);
        master_ready_i = 1'b1;
        // nothing may follow the last beat of the frame.
        repeat (DrainCycles) begin
            @(negedge clock_i);
            check_value({test.name, " extra beat"}, 0, master_valid_o);
        end
        master_ready_i = 1'b0;
    endtask

    initial begin
        reset_i = 1'b1;
        slave_valid_i = 1'b0;
        slave_data_i = '0;
        master_ready_i = 1'b0;
        repeat (16) @(posedge clock_i);
        @(negedge clock_i);
        reset_i = 1'b0;
        @(negedge clock_i);
        check_value("after_reset valid", 0, master_valid_o);
        check_value("after_reset ready", 1, slave_ready_o);
        foreach (tests[i]) begin
            run_test(tests[i]);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule : srcnn_small_tb

// File: vlog.f
+incdir+test
verilog/srcnn_pkg.sv
verilog/stream_fifo.sv
verilog/window_buffer.sv
verilog/convolve.sv
verilog/srcnn_small.sv
test/srcnn_small_tb.sv

// File: Bender.yml
package:
  name: srcnn_small

sources:
  - verilog/srcnn_pkg.sv
  - verilog/stream_fifo.sv
  - verilog/window_buffer.sv
  - verilog/convolve.sv
  - verilog/srcnn_small.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/srcnn_small_tb.sv
